//--- design/fpu_consts.svh
/*
 * FPU non-computational unit constants
 * register widths and canonical NaN patterns
 */
`ifndef FPU_CONSTS_SVH
`define FPU_CONSTS_SVH

// --------------------
// widths
// --------------------
`define FPU_XLEN   64     // register data width
`define FPU_REG_W  5      // register index width
`define FPU_PC_W   40     // pc width

// --------------------
// canonical NaNs
// --------------------
`define FPU_QNAN32 32'h7fc0_0000             // single precision qnan
`define FPU_QNAN64 64'h7ff8_0000_0000_0000   // double precision qnan

`endif

//--- design/fpu_data_pkg.sv
/*
 * FPU data-side types
 * operand views, exception flags and writeback structs
 */
`default_nettype none

`include "fpu_consts.svh"

package fpu_data_pkg;

   // --------------------
   // operand word
   // --------------------
   typedef struct packed {
      logic        sign;
      logic [10:0] exp;
      logic [51:0] man;
   } fp64_t;

   typedef struct packed {
      logic [31:0] box;     // all ones when properly boxed
      logic        sign;
      logic [7:0]  exp;
      logic [22:0] man;
   } fp32_boxed_t;

   // one 64-bit register word, two readings
   typedef union packed {
      fp64_t       d;       // double view
      fp32_boxed_t s;       // single view with box bits
   } fpu_operand_u;

   // accrued exception bits, fflags order
   typedef struct packed {
      logic nv;   // invalid
      logic dz;   // divide by zero
      logic of;   // overflow
      logic uf;   // underflow
      logic nx;   // inexact
   } fpu_flags_t;

   // --------------------
   // writebacks
   // --------------------
   typedef struct packed {
      logic                  valid;
      logic [`FPU_REG_W-1:0] rd;
      logic [`FPU_PC_W-1:0]  pc;
      logic [`FPU_XLEN-1:0]  result;
      fpu_flags_t            flags;
   } fpu_wb_fp_t;

   typedef struct packed {
      logic                  valid;
      logic [`FPU_REG_W-1:0] rd;
      logic [`FPU_PC_W-1:0]  pc;
      logic [`FPU_XLEN-1:0]  result;
      fpu_flags_t            flags;
   } fpu_wb_int_t;

endpackage

`default_nettype wire

//--- design/fpu_decode.sv
/*
 * FPU decode stage
 * accepts FPU instructions, unboxes FP32 operands and
 * holds them in the issue register
 */
`default_nettype none

`include "fpu_consts.svh"

module fpu_decode (
   input  logic                  clk_i,
   input  logic                  rstn_i,
   input  logic                  kill_i,
   input  logic                  hold_i,
   input  fpu_isa_pkg::fpu_issue_t issue_i,
   output fpu_isa_pkg::fpu_dec_t   dec_o
);

   import fpu_isa_pkg::*;
   import fpu_data_pkg::*;

   logic     accept;
   fpu_dec_t dec_d;
   fpu_dec_t dec_q;     // payload, no reset
   logic     dec_vld_q;

   // bad box bits read as canonical qnan
   function automatic fpu_operand_u unbox(fpu_operand_u v, fpu_fmt_e fmt);
      fpu_operand_u r;
      r = v;
      if (fmt == FP32 && v.s.box != '1) begin
         r = {{32{1'b1}}, `FPU_QNAN32};
      end
      return r;
   endfunction

   // --------------------
   // acceptance
   // --------------------
   assign accept = issue_i.valid & issue_i.unit_fpu & ~hold_i & ~kill_i;

   always_comb begin
      dec_d.valid = accept;
      dec_d.op    = issue_i.op;
      dec_d.fmt   = issue_i.fmt;
      dec_d.rd    = issue_i.rd;
      dec_d.pc    = issue_i.pc;
      // rs1 of fmv.x2f is integer data, never unboxed
      if (issue_i.op == FMV_X2F) begin
         dec_d.rs1 = issue_i.data_rs1;
      end else begin
         dec_d.rs1 = unbox(issue_i.data_rs1, issue_i.fmt);
      end
      dec_d.rs2     = unbox(issue_i.data_rs2, issue_i.fmt);
      dec_d.int_dst = issue_i.op inside {FEQ, FLT, FLE, FCLASS, FMV_F2X};
   end

   // --------------------
   // issue register
   // --------------------
   always_ff @(posedge clk_i, negedge rstn_i) begin
      if (~rstn_i) begin
         dec_vld_q <= 1'b0;
      end else if (kill_i) begin
         dec_vld_q <= 1'b0;         // flush wins over hold
      end else if (~hold_i) begin
         dec_vld_q <= accept;
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept) begin
         dec_q <= dec_d;            // only load on a real instruction
      end
   end

   always_comb begin
      dec_o       = dec_q;
      dec_o.valid = dec_vld_q;
   end

endmodule

`default_nettype wire

//--- design/fpu_execute.sv
/*
 * FPU execute stage, combinational
 * sign injection, min/max, compares, classify and moves
 */
`default_nettype none

`include "fpu_consts.svh"

module fpu_execute (
   input  fpu_isa_pkg::fpu_dec_t     dec_i,
   output fpu_data_pkg::fpu_wb_fp_t  fp_o,
   output fpu_data_pkg::fpu_wb_int_t int_o
);

   import fpu_isa_pkg::*;
   import fpu_data_pkg::*;

   typedef struct packed {
      logic sign;
      logic zero;
      logic sub;
      logic norm;
      logic inf;
      logic snan;
      logic qnan;
   } fp_class_t;

   fp_class_t            ca, cb;          // rs1 / rs2 classes
   logic [62:0]          mag_a, mag_b;    // exponent and mantissa
   logic                 mag_lt, mag_eq;
   logic                 lt_ord, eq_ord;
   logic                 both_zero, a_nan, b_nan, any_nan, any_snan;
   logic                 sgn;
   logic [9:0]           cls_mask;
   logic [`FPU_XLEN-1:0] qnan_fmt;
   logic [`FPU_XLEN-1:0] res;
   fpu_flags_t           flags;

   function automatic fp_class_t classify(fpu_operand_u v, fpu_fmt_e fmt);
      fp_class_t c;
      logic      exp_ones, exp_zero, man_zero, quiet;
      if (fmt == FP64) begin
         c.sign   = v.d.sign;
         exp_ones = &v.d.exp;
         exp_zero = ~|v.d.exp;
         man_zero = ~|v.d.man;
         quiet    = v.d.man[51];
      end else begin
         c.sign   = v.s.sign;
         exp_ones = &v.s.exp;
         exp_zero = ~|v.s.exp;
         man_zero = ~|v.s.man;
         quiet    = v.s.man[22];
      end
      c.zero = exp_zero & man_zero;
      c.sub  = exp_zero & ~man_zero;
      c.norm = ~exp_zero & ~exp_ones;
      c.inf  = exp_ones & man_zero;
      c.snan = exp_ones & ~man_zero & ~quiet;
      c.qnan = exp_ones & quiet;
      return c;
   endfunction

   // --------------------
   // operand analysis
   // --------------------
   assign ca = classify(dec_i.rs1, dec_i.fmt);
   assign cb = classify(dec_i.rs2, dec_i.fmt);

   assign mag_a = (dec_i.fmt == FP64) ? {dec_i.rs1.d.exp, dec_i.rs1.d.man}
                                      : {32'b0, dec_i.rs1.s.exp, dec_i.rs1.s.man};
   assign mag_b = (dec_i.fmt == FP64) ? {dec_i.rs2.d.exp, dec_i.rs2.d.man}
                                      : {32'b0, dec_i.rs2.s.exp, dec_i.rs2.s.man};

   // one magnitude compare shared by min/max and compares
   assign mag_lt = mag_a < mag_b;
   assign mag_eq = mag_a == mag_b;

   // signed ordering, -0 below +0
   assign lt_ord    = (ca.sign != cb.sign) ? ca.sign
                                           : (ca.sign ? (~mag_lt & ~mag_eq) : mag_lt);
   assign both_zero = ca.zero & cb.zero;
   assign eq_ord    = ((ca.sign == cb.sign) & mag_eq) | both_zero;   // +0 == -0

   assign a_nan    = ca.snan | ca.qnan;
   assign b_nan    = cb.snan | cb.qnan;
   assign any_nan  = a_nan | b_nan;
   assign any_snan = ca.snan | cb.snan;

   assign qnan_fmt = (dec_i.fmt == FP64) ? `FPU_QNAN64 : {{32{1'b1}}, `FPU_QNAN32};

   // riscv fclass bit order
   assign cls_mask = {ca.qnan, ca.snan,
                      ~ca.sign & ca.inf, ~ca.sign & ca.norm,
                      ~ca.sign & ca.sub, ~ca.sign & ca.zero,
                      ca.sign & ca.zero, ca.sign & ca.sub,
                      ca.sign & ca.norm, ca.sign & ca.inf};

   // --------------------
   // result select
   // --------------------
   always_comb begin
      res   = '0;
      flags = '0;
      case (dec_i.op)
         FSGNJ:  sgn = cb.sign;
         FSGNJN: sgn = ~cb.sign;
         default: sgn = ca.sign ^ cb.sign;   // fsgnjx
      endcase
      case (dec_i.op)
         FSGNJ, FSGNJN, FSGNJX: begin
            if (dec_i.fmt == FP64) begin
               res = {sgn, dec_i.rs1.d.exp, dec_i.rs1.d.man};
            end else begin
               res = {{32{1'b1}}, sgn, dec_i.rs1.s.exp, dec_i.rs1.s.man};
            end
         end
         FMIN, FMAX: begin
            flags.nv = any_snan;
            if (a_nan & b_nan)                       res = qnan_fmt;
            else if (a_nan)                          res = dec_i.rs2;  // other input wins
            else if (b_nan)                          res = dec_i.rs1;
            else if ((dec_i.op == FMIN) == lt_ord)   res = dec_i.rs1;
            else                                     res = dec_i.rs2;
         end
         FEQ: begin
            flags.nv = any_snan;           // quiet compare
            res[0]   = ~any_nan & eq_ord;
         end
         FLT: begin
            flags.nv = any_nan;            // signaling compare
            res[0]   = ~any_nan & lt_ord & ~both_zero;
         end
         FLE: begin
            flags.nv = any_nan;
            res[0]   = ~any_nan & (lt_ord | eq_ord);
         end
         FCLASS: res[9:0] = cls_mask;
         FMV_F2X: begin
            if (dec_i.fmt == FP64) res = dec_i.rs1;
            else                   res = {{32{dec_i.rs1[31]}}, dec_i.rs1[31:0]};  // sign extend
         end
         FMV_X2F: begin
            if (dec_i.fmt == FP64) res = dec_i.rs1;
            else                   res = {{32{1'b1}}, dec_i.rs1[31:0]};           // nan box
         end
         default: res = '0;
      endcase
   end

   // destination class picks the live output
   assign fp_o.valid   = dec_i.valid & ~dec_i.int_dst;
   assign fp_o.rd      = dec_i.rd;
   assign fp_o.pc      = dec_i.pc;
   assign fp_o.result  = res;
   assign fp_o.flags   = flags;

   assign int_o.valid  = dec_i.valid & dec_i.int_dst;
   assign int_o.rd     = dec_i.rd;
   assign int_o.pc     = dec_i.pc;
   assign int_o.result = res;
   assign int_o.flags  = flags;

endmodule

`default_nettype wire

//--- design/fpu_isa_pkg.sv
/*
 * FPU instruction-side types
 * operation kinds, formats, issued and decoded instruction
 */
`default_nettype none

`include "fpu_consts.svh"

package fpu_isa_pkg;

   // --------------------
   // operations
   // --------------------
   typedef enum logic [3:0] {
      NONE,
      FSGNJ,
      FSGNJN,
      FSGNJX,
      FMIN,
      FMAX,
      FEQ,
      FLT,
      FLE,
      FCLASS,
      FMV_X2F,     // integer to fp register
      FMV_F2X      // fp register to integer
   } fpu_op_e;

   typedef enum logic {
      FP32 = 1'b0,
      FP64 = 1'b1
   } fpu_fmt_e;

   // what the issue stage hands over
   typedef struct packed {
      logic                  valid;
      logic                  unit_fpu;    // instruction targets this unit
      fpu_op_e               op;
      fpu_fmt_e              fmt;
      logic [`FPU_REG_W-1:0] rd;
      logic [`FPU_PC_W-1:0]  pc;
      logic [`FPU_XLEN-1:0]  data_rs1;
      logic [`FPU_XLEN-1:0]  data_rs2;
   } fpu_issue_t;

   // issue register contents
   typedef struct packed {
      logic                       valid;
      fpu_op_e                    op;
      fpu_fmt_e                   fmt;
      logic [`FPU_REG_W-1:0]      rd;
      logic [`FPU_PC_W-1:0]       pc;
      fpu_data_pkg::fpu_operand_u rs1;
      fpu_data_pkg::fpu_operand_u rs2;
      logic                       int_dst;   // result goes to integer regfile
   } fpu_dec_t;

endpackage

`default_nettype wire

//--- design/fpu_noncomp_top.sv
/*
 * FPU non-computational unit
 * decode, execute and result stages, two-cycle latency
 */
`default_nettype none

module fpu_noncomp_top (
   input  logic                      clk_i,
   input  logic                      rstn_i,
   input  logic                      kill_i,
   input  logic                      wb_ready_i,
   input  fpu_isa_pkg::fpu_issue_t   issue_i,
   output logic                      stall_o,
   output fpu_data_pkg::fpu_wb_fp_t  wb_fp_o,
   output fpu_data_pkg::fpu_wb_int_t wb_int_o
);

   import fpu_isa_pkg::*;
   import fpu_data_pkg::*;

   fpu_dec_t    dec;        // issue register
   fpu_wb_fp_t  exe_fp;     // combinational results
   fpu_wb_int_t exe_int;
   logic        hold;       // back-pressure from the output register

   fpu_decode u_decode (
      .clk_i   (clk_i),
      .rstn_i  (rstn_i),
      .kill_i  (kill_i),
      .hold_i  (hold),
      .issue_i (issue_i),
      .dec_o   (dec)
   );

   fpu_execute u_execute (
      .dec_i (dec),
      .fp_o  (exe_fp),
      .int_o (exe_int)
   );

   fpu_result u_result (
      .clk_i      (clk_i),
      .rstn_i     (rstn_i),
      .kill_i     (kill_i),
      .wb_ready_i (wb_ready_i),
      .fp_i       (exe_fp),
      .int_i      (exe_int),
      .hold_o     (hold),
      .wb_fp_o    (wb_fp_o),
      .wb_int_o   (wb_int_o)
   );

   assign stall_o = hold;   // issue sees the same hold as decode

endmodule

`default_nettype wire

//--- design/fpu_result.sv
/*
 * FPU result stage
 * output register for both writebacks, back-pressure and kill
 */
`default_nettype none

module fpu_result (
   input  logic                      clk_i,
   input  logic                      rstn_i,
   input  logic                      kill_i,
   input  logic                      wb_ready_i,
   input  fpu_data_pkg::fpu_wb_fp_t  fp_i,
   input  fpu_data_pkg::fpu_wb_int_t int_i,
   output logic                      hold_o,
   output fpu_data_pkg::fpu_wb_fp_t  wb_fp_o,
   output fpu_data_pkg::fpu_wb_int_t wb_int_o
);

   import fpu_data_pkg::*;

   fpu_wb_fp_t  fp_q;       // payload registers
   fpu_wb_int_t int_q;
   logic        fp_vld_q;
   logic        int_vld_q;

   // stuck while a result waits for the consumer
   assign hold_o = (fp_vld_q | int_vld_q) & ~wb_ready_i;

   // --------------------
   // valid bits
   // --------------------
   always_ff @(posedge clk_i, negedge rstn_i) begin
      if (~rstn_i) begin
         fp_vld_q  <= 1'b0;
         int_vld_q <= 1'b0;
      end else if (kill_i) begin
         fp_vld_q  <= 1'b0;   // drop whatever is pending
         int_vld_q <= 1'b0;
      end else if (~hold_o) begin
         fp_vld_q  <= fp_i.valid;
         int_vld_q <= int_i.valid;
      end
   end

   always_ff @(posedge clk_i) begin
      if (~hold_o) begin
         fp_q  <= fp_i;
         int_q <= int_i;
      end
   end

   // --------------------
   // outputs
   // --------------------
   always_comb begin
      wb_fp_o        = fp_q;
      wb_fp_o.valid  = fp_vld_q;
      wb_int_o       = int_q;
      wb_int_o.valid = int_vld_q;
   end

endmodule

`default_nettype wire

//--- sim.f
+incdir+design
design/fpu_data_pkg.sv
design/fpu_isa_pkg.sv
design/fpu_decode.sv
design/fpu_execute.sv
design/fpu_result.sv
design/fpu_noncomp_top.sv
verification/fpu_noncomp_asserts.sv
verification/fpu_noncomp_tb.sv

//--- verification/fpu_noncomp_asserts.sv
/*
 * FPU non-computational unit assertions
 * writeback exclusivity, stability under stall, reset values
 */
`default_nettype none

module fpu_noncomp_asserts (
   input logic                      clk_i,
   input logic                      rstn_i,
   input logic                      kill_i,
   input logic                      stall_o,
   input fpu_data_pkg::fpu_wb_fp_t  wb_fp_o,
   input fpu_data_pkg::fpu_wb_int_t wb_int_o
);

   timeunit 1ns;
   timeprecision 100ps;

   int fail_cnt = 0;   // read by the testbench

   // at most one destination per result
   a_wb_onehot: assert property (@(posedge clk_i) disable iff (!rstn_i)
      !(wb_fp_o.valid && wb_int_o.valid))
      else begin
         fail_cnt++;
         $error("fp and int writeback valid in the same cycle");
      end

   // output register frozen while the consumer stalls
   a_stall_stable: assert property (@(posedge clk_i) disable iff (!rstn_i)
      (stall_o && !kill_i) |=> ($stable(wb_fp_o) && $stable(wb_int_o)))
      else begin
         fail_cnt++;
         $error("writeback changed while stall_o was high");
      end

   a_reset_idle: assert property (@(posedge clk_i)
      !rstn_i |=> (!wb_fp_o.valid && !wb_int_o.valid && !stall_o))
      else begin
         fail_cnt++;
         $error("valid or stall high during reset");
      end

endmodule

bind fpu_noncomp_top fpu_noncomp_asserts u_asserts (
   .clk_i    (clk_i),
   .rstn_i   (rstn_i),
   .kill_i   (kill_i),
   .stall_o  (stall_o),
   .wb_fp_o  (wb_fp_o),
   .wb_int_o (wb_int_o)
);

`default_nettype wire

//--- verification/fpu_noncomp_tb.sv
/*
 * FPU non-computational unit testbench
 * directed tests against a rule-based model, scoreboard
 * on both writebacks, cycle timeout
 */
`default_nettype none

`include "fpu_consts.svh"

module fpu_noncomp_tb;

   timeunit 1ns;
   timeprecision 100ps;

   import fpu_isa_pkg::*;
   import fpu_data_pkg::*;

   // --------------------
   // run length
   // --------------------
   localparam int NUM_INSTR        = 130;   // instructions issued over all tests
   localparam int CYCLES_PER_INSTR = 3;
   localparam int FIXED_CYCLES     = 100;   // reset, stall windows, drains
   localparam int TIMEOUT_CYCLES   = NUM_INSTR * CYCLES_PER_INSTR + FIXED_CYCLES;

   // double and boxed single operand constants
   localparam logic [63:0] ONE_D  = 64'h3ff0_0000_0000_0000;
   localparam logic [63:0] TWO_D  = 64'h4000_0000_0000_0000;
   localparam logic [63:0] MTWO_D = 64'hc000_0000_0000_0000;
   localparam logic [63:0] PZ_D   = 64'h0000_0000_0000_0000;
   localparam logic [63:0] MZ_D   = 64'h8000_0000_0000_0000;
   localparam logic [63:0] QN_D   = 64'h7ff8_0000_0000_0000;
   localparam logic [63:0] QNP_D  = 64'h7ff8_0000_0000_0001;   // qnan with payload
   localparam logic [63:0] SN_D   = 64'h7ff4_0000_0000_0000;
   localparam logic [63:0] ONE_S  = 64'hffff_ffff_3f80_0000;
   localparam logic [63:0] TWO_S  = 64'hffff_ffff_4000_0000;
   localparam logic [63:0] MTWO_S = 64'hffff_ffff_c000_0000;
   localparam logic [63:0] PZ_S   = 64'hffff_ffff_0000_0000;
   localparam logic [63:0] MZ_S   = 64'hffff_ffff_8000_0000;
   localparam logic [63:0] QN_S   = 64'hffff_ffff_7fc0_0000;
   localparam logic [63:0] QNP_S  = 64'hffff_ffff_7fc0_0001;
   localparam logic [63:0] SN_S   = 64'hffff_ffff_7fa0_0000;
   localparam logic [63:0] SIGN_S = 64'h0000_0000_8000_0000;   // single sign bit only

   typedef struct packed {
      logic        int_dst;
      logic        nv;
      logic [63:0] res;
   } exp_t;

   typedef struct packed {
      exp_t        e;
      logic [4:0]  rd;
      logic [39:0] pc;
      logic [31:0] acc_cycle;
   } wb_entry_t;

   logic        clk_i = 1'b0;
   logic        rstn_i;
   logic        kill_i;
   logic        wb_ready_i;
   fpu_issue_t  issue_i;
   logic        stall_o;
   fpu_wb_fp_t  wb_fp_o;
   fpu_wb_int_t wb_int_o;

   wb_entry_t   pending[$];      // accepted and not yet written back
   int          cycle = 0;
   int          val_errors = 0;
   int          other_errors = 0;
   int          total_errors;
   logic        check_latency = 1'b0;
   logic [39:0] pc_cnt = '0;

   fpu_noncomp_top uut (
      .clk_i      (clk_i),
      .rstn_i     (rstn_i),
      .kill_i     (kill_i),
      .wb_ready_i (wb_ready_i),
      .issue_i    (issue_i),
      .stall_o    (stall_o),
      .wb_fp_o    (wb_fp_o),
      .wb_int_o   (wb_int_o)
   );

   always #2 clk_i = ~clk_i;   // 4 ns period

   // --------------------
   // checking
   // --------------------
   task automatic check_val(string name, logic [63:0] got, logic [63:0] exp);
      if (got !== exp) begin
         val_errors++;
         $display("[ERROR] %0t %s: got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic report_failure(string what);
      other_errors++;
      $display("%0t failure: %s", $time, what);
   endtask

   // --------------------
   // reference model
   // --------------------
   function automatic logic [63:0] unbox_ref(logic [63:0] v, logic is64);
      if (!is64 && v[63:32] != 32'hffff_ffff) begin
         return {32'hffff_ffff, `FPU_QNAN32};
      end
      return v;
   endfunction

   function automatic logic sign_of(logic [63:0] v, logic is64);
      return is64 ? v[63] : v[31];
   endfunction

   function automatic logic exp_all_ones(logic [63:0] v, logic is64);
      return is64 ? (&v[62:52]) : (&v[30:23]);
   endfunction

   function automatic logic frac_zero(logic [63:0] v, logic is64);
      return is64 ? (v[51:0] == '0) : (v[22:0] == '0);
   endfunction

   function automatic logic is_nan(logic [63:0] v, logic is64);
      return exp_all_ones(v, is64) && !frac_zero(v, is64);
   endfunction

   function automatic logic is_snan(logic [63:0] v, logic is64);
      return is_nan(v, is64) && !(is64 ? v[51] : v[22]);
   endfunction

   function automatic logic is_zero(logic [63:0] v, logic is64);
      return is64 ? (v[62:0] == '0) : (v[30:0] == '0);
   endfunction

   // sign-magnitude mapped to unsigned order with -0 below +0
   function automatic logic [63:0] order_key(logic [63:0] v, logic is64);
      logic [63:0] w;
      w = is64 ? v : {v[31:0], 32'b0};
      return w[63] ? ~w : {1'b1, w[62:0]};
   endfunction

   // riscv fclass bit index
   function automatic int class_bit(logic [63:0] v, logic is64);
      logic s;
      s = sign_of(v, is64);
      if (is_nan(v, is64)) return is_snan(v, is64) ? 8 : 9;
      if (exp_all_ones(v, is64)) return s ? 0 : 7;
      if (is_zero(v, is64)) return s ? 3 : 4;
      if (is64 ? (v[62:52] == '0) : (v[30:23] == '0)) return s ? 2 : 5;
      return s ? 1 : 6;
   endfunction

   function automatic exp_t model(fpu_op_e op, fpu_fmt_e fmt, logic [63:0] a_raw,
                                  logic [63:0] b_raw);
      exp_t        e;
      logic        is64;
      logic [63:0] a;
      logic [63:0] b;
      logic [63:0] qn;
      logic        an;
      logic        bn;
      logic        zz;
      logic        s;
      is64 = (fmt == FP64);
      a    = (op == FMV_X2F) ? a_raw : unbox_ref(a_raw, is64);   // x2f source is integer
      b    = unbox_ref(b_raw, is64);
      qn   = is64 ? `FPU_QNAN64 : {32'hffff_ffff, `FPU_QNAN32};
      an   = is_nan(a, is64);
      bn   = is_nan(b, is64);
      zz   = is_zero(a, is64) && is_zero(b, is64);
      e    = '0;
      e.int_dst = op inside {FEQ, FLT, FLE, FCLASS, FMV_F2X};
      case (op)
         FSGNJ, FSGNJN, FSGNJX: begin
            if (op == FSGNJ) s = sign_of(b, is64);
            else if (op == FSGNJN) s = !sign_of(b, is64);
            else s = sign_of(a, is64) ^ sign_of(b, is64);
            e.res = is64 ? {s, a[62:0]} : {32'hffff_ffff, s, a[30:0]};
         end
         FMIN, FMAX: begin
            e.nv = is_snan(a, is64) || is_snan(b, is64);
            if (an && bn) e.res = qn;
            else if (an) e.res = b;
            else if (bn) e.res = a;
            else if ((order_key(a, is64) < order_key(b, is64)) == (op == FMIN)) e.res = a;
            else e.res = b;
         end
         FEQ: begin
            e.nv  = is_snan(a, is64) || is_snan(b, is64);
            e.res = !(an || bn) && (a == b || zz);
         end
         FLT: begin
            e.nv  = an || bn;
            e.res = !(an || bn) && !zz && (order_key(a, is64) < order_key(b, is64));
         end
         FLE: begin
            e.nv  = an || bn;
            e.res = !(an || bn) && (zz || order_key(a, is64) <= order_key(b, is64));
         end
         FCLASS:  e.res = 64'd1 << class_bit(a, is64);
         FMV_F2X: e.res = is64 ? a : {{32{a[31]}}, a[31:0]};
         FMV_X2F: e.res = is64 ? a : {32'hffff_ffff, a[31:0]};
         default: e.res = '0;
      endcase
      return e;
   endfunction

   // --------------------
   // scoreboard and timeout
   // --------------------
   task automatic compare_wb;
      wb_entry_t   w;
      string       pfx;
      logic [4:0]  got_rd;
      logic [39:0] got_pc;
      logic [63:0] got_res;
      logic [4:0]  got_flags;
      if (pending.size() == 0) begin
         report_failure("writeback seen with no instruction in flight");
      end else begin
         w = pending.pop_front();
         check_val("wb_int_o.valid", wb_int_o.valid, w.e.int_dst);
         check_val("wb_fp_o.valid", wb_fp_o.valid, !w.e.int_dst);
         if (wb_int_o.valid) begin
            pfx       = "wb_int_o";
            got_rd    = wb_int_o.rd;
            got_pc    = wb_int_o.pc;
            got_res   = wb_int_o.result;
            got_flags = wb_int_o.flags;
         end else begin
            pfx       = "wb_fp_o";
            got_rd    = wb_fp_o.rd;
            got_pc    = wb_fp_o.pc;
            got_res   = wb_fp_o.result;
            got_flags = wb_fp_o.flags;
         end
         check_val({pfx, ".rd"}, got_rd, w.rd);
         check_val({pfx, ".pc"}, got_pc, w.pc);
         check_val({pfx, ".result"}, got_res, w.e.res);
         check_val({pfx, ".flags"}, got_flags, {w.e.nv, 4'b0});
         if (check_latency) begin
            check_val("latency", cycle - w.acc_cycle, 2);
         end
      end
   endtask

   task automatic record_issue;
      wb_entry_t w;
      w.e         = model(issue_i.op, issue_i.fmt, issue_i.data_rs1, issue_i.data_rs2);
      w.rd        = issue_i.rd;
      w.pc        = issue_i.pc;
      w.acc_cycle = cycle;
      pending.push_back(w);
   endtask

   // sampled before the register updates of this edge land
   always @(posedge clk_i) begin
      cycle = cycle + 1;
      if (cycle > TIMEOUT_CYCLES) begin
         $display("timeout: run exceeded %0d cycles", TIMEOUT_CYCLES);
         $display("Simulation failed");
         $finish;
      end else if (rstn_i) begin
         if (kill_i) begin
            pending.delete();            // both stages flushed
         end else begin
            if (wb_fp_o.valid && wb_int_o.valid) begin
               report_failure("both writebacks valid at once");
            end
            if ((wb_fp_o.valid || wb_int_o.valid) && wb_ready_i) compare_wb();
            if (issue_i.valid && issue_i.unit_fpu && !stall_o) record_issue();
         end
      end
   end

   // --------------------
   // drivers
   // --------------------
   function automatic logic [63:0] fmt_value(fpu_fmt_e fmt, logic [63:0] d, logic [63:0] s);
      return (fmt == FP64) ? d : s;
   endfunction

   task automatic drive_issue(fpu_op_e op, fpu_fmt_e fmt, logic [63:0] a, logic [63:0] b,
                              logic unit);
      @(negedge clk_i);
      pc_cnt            = pc_cnt + 1;
      issue_i.valid     = 1'b1;
      issue_i.unit_fpu  = unit;
      issue_i.op        = op;
      issue_i.fmt       = fmt;
      issue_i.rd        = pc_cnt[4:0];
      issue_i.pc        = pc_cnt;
      issue_i.data_rs1  = a;
      issue_i.data_rs2  = b;
   endtask

   task automatic wait_accept;
      logic acc;
      acc = 1'b0;
      while (!acc) begin
         @(posedge clk_i);
         acc = issue_i.valid & issue_i.unit_fpu & ~stall_o & ~kill_i;
      end
   endtask

   task automatic issue_instr(fpu_op_e op, fpu_fmt_e fmt, logic [63:0] a, logic [63:0] b);
      drive_issue(op, fmt, a, b, 1'b1);
      wait_accept();
   endtask

   task automatic issue_idle;
      @(negedge clk_i);
      issue_i.valid = 1'b0;
   endtask

   task automatic drain;
      issue_idle();
      while (pending.size() != 0) @(negedge clk_i);
      @(negedge clk_i);
   endtask

   // --------------------
   // tests
   // --------------------
   task automatic test_sign_move;
      fpu_fmt_e fmt;
      check_latency = 1'b1;
      for (int f = 0; f < 2; f++) begin
         fmt = fpu_fmt_e'(f);
         issue_instr(FSGNJ, fmt, fmt_value(fmt, TWO_D, TWO_S), fmt_value(fmt, MTWO_D, MTWO_S));
         issue_instr(FSGNJN, fmt, fmt_value(fmt, TWO_D, TWO_S), fmt_value(fmt, MTWO_D, MTWO_S));
         issue_instr(FSGNJX, fmt, fmt_value(fmt, MTWO_D, MTWO_S), fmt_value(fmt, MTWO_D, MTWO_S));
      end
      issue_instr(FSGNJ, FP32, 64'h0000_0000_4000_0000, MTWO_S);   // bad box on rs1
      issue_instr(FMV_F2X, FP32, 64'hffff_ffff_bf80_0000, PZ_S);   // negative value sign extends
      issue_instr(FMV_F2X, FP32, ONE_S, PZ_S);
      issue_instr(FMV_F2X, FP64, 64'hc123_4567_89ab_cdef, PZ_D);
      issue_instr(FMV_X2F, FP32, 64'h1234_5678_3f80_0000, PZ_S);
      issue_instr(FMV_X2F, FP64, 64'h1234_5678_9abc_def0, PZ_D);
      drain();
   endtask

   task automatic test_min_max;
      logic [63:0] pa [7];
      logic [63:0] pb [7];
      fpu_fmt_e    fmt;
      check_latency = 1'b1;
      for (int f = 0; f < 2; f++) begin
         fmt   = fpu_fmt_e'(f);
         pa[0] = fmt_value(fmt, MZ_D, MZ_S);
         pb[0] = fmt_value(fmt, PZ_D, PZ_S);
         pa[1] = fmt_value(fmt, PZ_D, PZ_S);
         pb[1] = fmt_value(fmt, MZ_D, MZ_S);
         pa[2] = fmt_value(fmt, ONE_D, ONE_S);
         pb[2] = fmt_value(fmt, QN_D, QN_S);
         pa[3] = fmt_value(fmt, QN_D, QN_S);
         pb[3] = fmt_value(fmt, MTWO_D, MTWO_S);
         pa[4] = fmt_value(fmt, QNP_D, QNP_S);   // two nans, neither canonical
         pb[4] = fmt_value(fmt, SN_D, SN_S);
         pa[5] = fmt_value(fmt, SN_D, SN_S);     // signaling nan sets nv
         pb[5] = fmt_value(fmt, TWO_D, TWO_S);
         pa[6] = fmt_value(fmt, ONE_D, ONE_S);
         pb[6] = fmt_value(fmt, MTWO_D, MTWO_S);
         for (int i = 0; i < 7; i++) begin
            issue_instr(FMIN, fmt, pa[i], pb[i]);
            issue_instr(FMAX, fmt, pa[i], pb[i]);
         end
      end
      drain();
   endtask

   task automatic test_compare;
      logic [63:0] a;
      logic [63:0] b;
      fpu_fmt_e    fmt;
      check_latency = 1'b1;
      for (int f = 0; f < 2; f++) begin
         fmt = fpu_fmt_e'(f);
         for (int i = 0; i < 8; i++) begin
            a = fmt_value(fmt, {$urandom, $urandom}, {32'hffff_ffff, $urandom});
            b = fmt_value(fmt, {$urandom, $urandom}, {32'hffff_ffff, $urandom});
            if (i % 3 == 0) b = a;                                      // equal operands
            if (i % 3 == 1) b = fmt_value(fmt, a ^ MZ_D, a ^ SIGN_S);   // opposite sign
            issue_instr(FEQ, fmt, a, b);
            issue_instr(FLT, fmt, a, b);
            issue_instr(FLE, fmt, a, b);
         end
         issue_instr(FEQ, fmt, fmt_value(fmt, QN_D, QN_S), fmt_value(fmt, ONE_D, ONE_S));
         issue_instr(FEQ, fmt, fmt_value(fmt, SN_D, SN_S), fmt_value(fmt, ONE_D, ONE_S));
         issue_instr(FLT, fmt, fmt_value(fmt, QN_D, QN_S), fmt_value(fmt, ONE_D, ONE_S));
         issue_instr(FLE, fmt, fmt_value(fmt, ONE_D, ONE_S), fmt_value(fmt, QN_D, QN_S));
         issue_instr(FLT, fmt, fmt_value(fmt, MZ_D, MZ_S), fmt_value(fmt, PZ_D, PZ_S));
         issue_instr(FLE, fmt, fmt_value(fmt, MZ_D, MZ_S), fmt_value(fmt, PZ_D, PZ_S));
         issue_instr(FEQ, fmt, fmt_value(fmt, MZ_D, MZ_S), fmt_value(fmt, PZ_D, PZ_S));
      end
      drain();
   endtask

   task automatic test_classify;
      logic [63:0] cls_d [10];
      logic [63:0] cls_s [10];
      check_latency = 1'b1;
      // fclass bit order -inf -norm -sub -0 +0 +sub +norm +inf snan qnan
      cls_d = '{64'hfff0_0000_0000_0000, MTWO_D, 64'h8000_0000_0000_0001, MZ_D, PZ_D,
                64'h0000_0000_0000_0001, ONE_D, 64'h7ff0_0000_0000_0000, SN_D, QN_D};
      cls_s = '{64'hffff_ffff_ff80_0000, MTWO_S, 64'hffff_ffff_8000_0001, MZ_S, PZ_S,
                64'hffff_ffff_0000_0001, ONE_S, 64'hffff_ffff_7f80_0000, SN_S, QN_S};
      for (int i = 0; i < 10; i++) begin
         issue_instr(FCLASS, FP64, cls_d[i], PZ_D);
         issue_instr(FCLASS, FP32, cls_s[i], PZ_S);
      end
      issue_instr(FCLASS, FP32, 64'h0000_0000_3f80_0000, PZ_S);   // unboxed operand reads as qnan
      drain();
   endtask

   task automatic test_backpressure;
      fpu_wb_fp_t  snap_fp;
      fpu_wb_int_t snap_int;
      check_latency = 1'b0;
      @(negedge clk_i);
      wb_ready_i = 1'b0;
      issue_instr(FSGNJN, FP64, ONE_D, ONE_D);
      issue_instr(FEQ, FP32, ONE_S, ONE_S);
      drive_issue(FCLASS, FP64, MTWO_D, PZ_D, 1'b1);   // waits behind the stall
      snap_fp  = wb_fp_o;
      snap_int = wb_int_o;
      repeat (5) begin
         @(negedge clk_i);
         check_val("stall_o", stall_o, 1'b1);
         check_val("outputs stable", (wb_fp_o == snap_fp) && (wb_int_o == snap_int), 1'b1);
      end
      wb_ready_i = 1'b1;
      wait_accept();
      drain();
   endtask

   task automatic test_kill_ignore;
      check_latency = 1'b0;
      @(negedge clk_i);
      wb_ready_i = 1'b0;
      issue_instr(FMAX, FP64, ONE_D, TWO_D);
      issue_instr(FLT, FP64, ONE_D, TWO_D);
      @(negedge clk_i);
      issue_i.valid = 1'b0;
      kill_i        = 1'b1;                 // both stages occupied
      @(negedge clk_i);
      kill_i     = 1'b0;
      wb_ready_i = 1'b1;
      check_val("wb_fp_o.valid", wb_fp_o.valid, 1'b0);
      check_val("wb_int_o.valid", wb_int_o.valid, 1'b0);
      // kill also blocks acceptance
      drive_issue(FSGNJ, FP64, ONE_D, MTWO_D, 1'b1);
      kill_i = 1'b1;
      @(negedge clk_i);
      kill_i        = 1'b0;
      issue_i.valid = 1'b0;
      drive_issue(FMIN, FP64, ONE_D, TWO_D, 1'b0);   // other unit
      repeat (5) begin
         @(negedge clk_i);
         check_val("wb_fp_o.valid", wb_fp_o.valid, 1'b0);
         check_val("wb_int_o.valid", wb_int_o.valid, 1'b0);
      end
      issue_i.valid = 1'b0;
   endtask

   // --------------------
   // main sequence
   // --------------------
   initial begin
      void'($urandom(47109));
      issue_i    = '0;
      kill_i     = 1'b0;
      wb_ready_i = 1'b1;
      rstn_i     = 1'b0;
      repeat (8) @(posedge clk_i);
      @(negedge clk_i);
      rstn_i = 1'b1;

      test_sign_move();
      test_min_max();
      test_compare();
      test_classify();
      test_backpressure();
      test_kill_ignore();

      total_errors = val_errors + other_errors + uut.u_asserts.fail_cnt;
      $display("errors: %0d value mismatches, %0d other failures, %0d assertion failures",
               val_errors, other_errors, uut.u_asserts.fail_cnt);
      if (total_errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
